//--- vlog.f
rtl/dcache_pkg.sv
rtl/mem_bus_if.sv
rtl/cache_array.sv
rtl/fill_counter.sv
rtl/dcache_fsm.sv
rtl/multicycle_memory.sv
rtl/dcache_top.sv
verification/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_dcache \
    -f vlog.f \
    -o tb_dcache

./obj_dir/tb_dcache

//--- verification/tb_dcache.sv
module tb_dcache import dcache_pkg::*; ();

    // Worst case is 256 writes plus 400 misses of 8 + LATENCY + 3 cycles, with margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NUM_RANDOM_OPS = 400;

    logic  clk;
    logic  rst_n_i;
    logic  req_i;
    logic  we_i;
    addr_t addr_i;
    word_t wdata_i;
    logic  busy_o;
    logic  rvalid_o;
    word_t rdata_o;

    // Reference model of backing memory and of which block each set holds
    word_t              mem_model [1 << ADDR_W];
    logic [NUM_SETS-1:0] res_valid;
    tag_t               res_tag [NUM_SETS];

    int seed = 32'h1990_7366;
    int cycles = 0;

    dcache_top UUT (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .busy_o   (busy_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("** FAIL **");
            $fatal(1, "simulation timed out after %0d cycles", cycles);
        end
    end

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input addr_t addr);
        if (got !== exp) begin
            report_failure($sformatf("read of 0x%h returned 0x%h, expected 0x%h",
                                     addr, got, exp));
        end
    endtask

    task automatic check_miss(input logic got_busy, input logic exp_miss, input addr_t addr);
        if (got_busy !== exp_miss) begin
            report_failure($sformatf("access to 0x%h: busy_o=%b, model expects miss=%b",
                                     addr, got_busy, exp_miss));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // Called one unit after a rising edge; returns one unit after the accepting edge
    task automatic write_word(input addr_t addr, input word_t data);
        while (busy_o) begin
            @(posedge clk);
            #1;
        end
        req_i   = 1'b1;
        we_i    = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        @(posedge clk);
        #1;
        req_i = 1'b0;
        check_miss(busy_o, 1'b0, addr);
        check_bit(rvalid_o, 1'b0, "rvalid_o after a write");
        // Write-through without allocation, residency is unchanged
        mem_model[addr] = data;
    endtask

    task automatic read_word(input addr_t addr);
        logic [INDEX_W-1:0] set;
        tag_t               tag;
        logic               exp_miss;
        set      = addr[OFFSET_W +: INDEX_W];
        tag      = addr[ADDR_W-1 -: TAG_W];
        exp_miss = !(res_valid[set] && (res_tag[set] == tag));
        while (busy_o) begin
            @(posedge clk);
            #1;
        end
        req_i   = 1'b1;
        we_i    = 1'b0;
        addr_i  = addr;
        wdata_i = '0;
        @(posedge clk);
        #1;
        req_i = 1'b0;
        check_miss(busy_o, exp_miss, addr);
        // Fill length depends on LATENCY, so follow busy_o until it drops
        while (busy_o) begin
            check_bit(rvalid_o, 1'b0, "rvalid_o during a fill");
            @(posedge clk);
            #1;
        end
        check_bit(rvalid_o, 1'b1, "rvalid_o in the response cycle");
        check_word(rdata_o, mem_model[addr], addr);
        if (exp_miss) begin
            res_valid[set] = 1'b1;
            res_tag[set]   = tag;
        end
        // Exactly one response pulse per read
        @(posedge clk);
        #1;
        check_bit(rvalid_o, 1'b0, "rvalid_o one cycle after the response");
    endtask

    initial begin
        logic [31:0] rnd;
        addr_t       op_addr;
        word_t       op_data;
        rst_n_i   = 1'b0;
        req_i     = 1'b0;
        we_i      = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        res_valid = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_bit(busy_o, 1'b0, "busy_o after reset");
        check_bit(rvalid_o, 1'b0, "rvalid_o after reset");

        // Fill the whole memory, no block becomes resident
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            write_word(addr_t'(i), word_t'($random(seed)));
        end

        // Directed hit, write hit, no-allocate and replacement cases
        read_word(8'h13);
        read_word(8'h13);
        read_word(8'h17);
        write_word(8'h13, word_t'($random(seed)));
        read_word(8'h13);
        write_word(8'h5b, word_t'($random(seed)));
        read_word(8'h5b);
        read_word(8'h53);
        read_word(8'h13);

        for (int n = 0; n < NUM_RANDOM_OPS; n++) begin
            rnd     = $random(seed);
            op_addr = addr_t'($random(seed));
            op_data = word_t'($random(seed));
            if (rnd[0]) begin
                write_word(op_addr, op_data);
            end else begin
                read_word(op_addr);
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

//--- rtl/dcache_top.sv
module dcache_top import dcache_pkg::*; #(
    parameter int LATENCY = 4
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  req_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    output logic  busy_o,
    output logic  rvalid_o,
    output word_t rdata_o
);

    mem_bus_if bus ();

    meta_t                       meta_rd, meta_wr;
    logic [INDEX_W-1:0]          meta_idx;
    logic                        meta_we;
    word_t                       data_rd, data_wr;
    logic [INDEX_W+OFFSET_W-1:0] data_idx;
    logic                        data_we;
    logic                        fill_start, issue;
    logic [OFFSET_W-1:0]         issue_idx, ret_idx;
    logic                        issue_done, ret_done;

    dcache_fsm u_fsm (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .busy_o       (busy_o),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .bus          (bus.controller),
        .meta_rd_i    (meta_rd),
        .meta_idx_o   (meta_idx),
        .meta_we_o    (meta_we),
        .meta_wr_o    (meta_wr),
        .data_idx_o   (data_idx),
        .data_rd_i    (data_rd),
        .data_we_o    (data_we),
        .data_wr_o    (data_wr),
        .fill_start_o (fill_start),
        .issue_o      (issue),
        .issue_idx_i  (issue_idx),
        .ret_idx_i    (ret_idx),
        .issue_done_i (issue_done),
        .ret_done_i   (ret_done)
    );

    // Every memory return during a fill is one block word
    fill_counter u_fill_counter (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .start_i      (fill_start),
        .issue_i      (issue),
        .ret_i        (bus.rvalid),
        .issue_idx_o  (issue_idx),
        .ret_idx_o    (ret_idx),
        .issue_done_o (issue_done),
        .ret_done_o   (ret_done)
    );

    cache_array #(.DEPTH(NUM_SETS), .ENTRY_T(meta_t)) meta_array (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (meta_we),
        .waddr_i (meta_idx),
        .wdata_i (meta_wr),
        .raddr_i (meta_idx),
        .rdata_o (meta_rd)
    );

    cache_array #(.DEPTH(NUM_SETS * BLOCK_WORDS), .ENTRY_T(word_t)) data_array (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (data_we),
        .waddr_i (data_idx),
        .wdata_i (data_wr),
        .raddr_i (data_idx),
        .rdata_o (data_rd)
    );

    multicycle_memory #(.LATENCY(LATENCY)) u_memory (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (bus.memory)
    );

endmodule

//--- rtl/multicycle_memory.sv
module multicycle_memory import dcache_pkg::*; #(
    parameter int LATENCY = 4
) (
    input logic       clk,
    input logic       rst_n_i,
    mem_bus_if.memory bus
);

    localparam int MEM_WORDS = 1 << ADDR_W;

    word_t              mem [MEM_WORDS];
    logic [LATENCY-1:0] pipe_valid;
    word_t              pipe_data [LATENCY];
    logic               rd_acc, wr_acc;

    assign rd_acc = bus.req && !bus.we;
    assign wr_acc = bus.req && bus.we;

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    // Stage 0 holds the word sampled at acceptance
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= rd_acc;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            pipe_data[0] <= mem[bus.addr];
        end
        for (int i = 1; i < LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign bus.rvalid = pipe_valid[LATENCY-1];
    assign bus.rdata  = pipe_data[LATENCY-1];

    // Write-through must not overtake reads still in the pipe
    a_no_write_in_flight: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wr_acc |-> (pipe_valid == '0)
    ) else $error("multicycle_memory: write while reads in flight");

endmodule

//--- rtl/dcache_fsm.sv
module dcache_fsm import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        req_i,
    input  logic                        we_i,
    input  addr_t                       addr_i,
    input  word_t                       wdata_i,
    output logic                        busy_o,
    output logic                        rvalid_o,
    output word_t                       rdata_o,
    mem_bus_if.controller               bus,
    input  meta_t                       meta_rd_i,
    output logic [INDEX_W-1:0]          meta_idx_o,
    output logic                        meta_we_o,
    output meta_t                       meta_wr_o,
    output logic [INDEX_W+OFFSET_W-1:0] data_idx_o,
    input  word_t                       data_rd_i,
    output logic                        data_we_o,
    output word_t                       data_wr_o,
    output logic                        fill_start_o,
    output logic                        issue_o,
    input  logic [OFFSET_W-1:0]         issue_idx_i,
    input  logic [OFFSET_W-1:0]         ret_idx_i,
    input  logic                        issue_done_i,
    input  logic                        ret_done_i
);

    typedef enum logic [1:0] {IDLE, FILL, RESP} state_t;

    state_t state_q, state_d;

    tag_t                req_tag, miss_tag;
    logic [INDEX_W-1:0]  req_idx, miss_idx;
    logic [OFFSET_W-1:0] req_off, miss_off;

    addr_t miss_addr_q;
    logic  hit, accept, rd_hit, rd_miss, wr_acc;
    logic  wr_pend_q;
    addr_t wr_addr_q;
    word_t wr_data_q;
    logic  rsp_valid_q;
    word_t rsp_data_q;

    assign req_tag  = addr_i[ADDR_W-1 -: TAG_W];
    assign req_idx  = addr_i[OFFSET_W +: INDEX_W];
    assign req_off  = addr_i[OFFSET_W-1:0];
    assign miss_tag = miss_addr_q[ADDR_W-1 -: TAG_W];
    assign miss_idx = miss_addr_q[OFFSET_W +: INDEX_W];
    assign miss_off = miss_addr_q[OFFSET_W-1:0];

    // Only the fill blocks the pipeline; RESP accepts like IDLE
    assign busy_o  = (state_q == FILL);
    assign accept  = req_i && !busy_o;
    assign hit     = meta_rd_i.valid && (meta_rd_i.tag == req_tag);
    assign rd_hit  = accept && !we_i && hit;
    assign rd_miss = accept && !we_i && !hit;
    assign wr_acc  = accept && we_i;

    // Array ports follow the fill while busy, else the pipeline address
    assign meta_idx_o = busy_o ? miss_idx : req_idx;
    assign meta_we_o  = busy_o && ret_done_i;
    assign meta_wr_o  = '{valid: 1'b1, tag: miss_tag};
    assign data_idx_o = busy_o ? {miss_idx, ret_idx_i} : {req_idx, req_off};
    assign data_we_o  = busy_o ? bus.rvalid : (wr_acc && hit);
    assign data_wr_o  = busy_o ? bus.rdata : wdata_i;

    assign fill_start_o = rd_miss;
    assign issue_o      = busy_o && !issue_done_i;

    // Write-through and fill reads never share a cycle
    assign bus.req   = wr_pend_q || issue_o;
    assign bus.we    = wr_pend_q;
    assign bus.addr  = wr_pend_q ? wr_addr_q : {miss_tag, miss_idx, issue_idx_i};
    assign bus.wdata = wr_data_q;

    assign rvalid_o = rsp_valid_q;
    assign rdata_o  = rsp_data_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FILL: begin
                if (ret_done_i) begin
                    state_d = RESP;
                end
            end
            default: state_d = rd_miss ? FILL : IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            wr_pend_q   <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            wr_pend_q   <= wr_acc;
            rsp_valid_q <= rd_hit || (busy_o && ret_done_i);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_miss) begin
            miss_addr_q <= addr_i;
        end
        if (wr_acc) begin
            wr_addr_q <= addr_i;
            wr_data_q <= wdata_i;
        end
        // Requested word is caught on its way into the data array
        if (rd_hit) begin
            rsp_data_q <= data_rd_i;
        end else if (busy_o && bus.rvalid && (ret_idx_i == miss_off)) begin
            rsp_data_q <= bus.rdata;
        end
    end

    a_no_req_in_resp: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state_q == RESP) |-> !bus.req
    ) else $error("dcache_fsm: bus request during response");

    a_rvalid_in_fill: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        bus.rvalid |-> (state_q == FILL)
    ) else $error("dcache_fsm: memory return outside fill");

    a_busy_xor_rvalid: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(busy_o && rvalid_o)
    ) else $error("dcache_fsm: busy and rvalid together");

endmodule

//--- rtl/fill_counter.sv
module fill_counter import dcache_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  logic                issue_i,
    input  logic                ret_i,
    output logic [OFFSET_W-1:0] issue_idx_o,
    output logic [OFFSET_W-1:0] ret_idx_o,
    output logic                issue_done_o,
    output logic                ret_done_o
);

    // Bit 0 tracks issued reads, bit 1 tracks returned words
    logic [1:0] step;

    assign step = {ret_i, issue_i};

    for (genvar g = 0; g < 2; g++) begin : g_cnt
        logic [OFFSET_W-1:0] cnt;
        logic                done;

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                cnt  <= '0;
                done <= 1'b0;
            end else if (start_i) begin
                cnt  <= '0;
                done <= 1'b0;
            end else if (step[g] && !done) begin
                cnt <= cnt + 1'b1;
                // Eighth step wraps the count and marks the block complete
                if (cnt == OFFSET_W'(BLOCK_WORDS - 1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    assign issue_idx_o  = g_cnt[0].cnt;
    assign issue_done_o = g_cnt[0].done;
    assign ret_idx_o    = g_cnt[1].cnt;
    assign ret_done_o   = g_cnt[1].done;

    // Memory must not return more words than the block holds
    a_no_extra_return: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ret_i |-> !ret_done_o
    ) else $error("fill_counter: return after block complete");

endmodule

//--- rtl/cache_array.sv
module cache_array #(
    parameter int  DEPTH   = 8,
    parameter type ENTRY_T = logic
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  ENTRY_T                   wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output ENTRY_T                   rdata_o
);

    ENTRY_T entries [DEPTH];

    // Clearing on reset leaves every meta entry invalid
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (we_i) begin
            entries[waddr_i] <= wdata_i;
        end
    end

    // Combinational read, a write shows up after the edge
    assign rdata_o = entries[raddr_i];

endmodule

//--- rtl/mem_bus_if.sv
interface mem_bus_if import dcache_pkg::*; ();

    // Request side, one strobe per accepted access
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;

    // Read return, in issue order
    logic  rvalid;
    word_t rdata;

    modport controller (
        output req,
        output we,
        output addr,
        output wdata,
        input  rvalid,
        input  rdata
    );

    modport memory (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rvalid,
        output rdata
    );

endinterface

//--- rtl/dcache_pkg.sv
package dcache_pkg;

    // Word and address widths
    localparam int WORD_W   = 16;
    localparam int ADDR_W   = 8;

    // Address split: tag | index | offset
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 3;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    localparam int BLOCK_WORDS = 1 << OFFSET_W;
    localparam int NUM_SETS    = 1 << INDEX_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // Per-set state, valid bit sits above the tag
    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

endpackage
